/* ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

`define XLEN       32   // data and pc width
`define NUM_REGS   32
`define REG_IDX_W  5
`define ROB_DEPTH  16   // window entries
`define ROB_IDX_W  4    // entry tag width
`define MUL_CYCLES 3    // multiply latency in cycles

`endif

/* ooo_pkg.sv */
package ooo_pkg;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,  // rs1 plus imm
        OP_MUL,   // low 32 bits of the product
        OP_BEQ,
        OP_BNE
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_EMPTY,
        ST_WAITING,  // allocated, waiting for operands or for the alu
        ST_EXEC,
        ST_DONE
    } entry_state_e;

endpackage

/* reg_file.sv */
`timescale 1ns/1ns
`include "ooo_defines.svh"

module reg_file (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic [`REG_IDX_W-1:0] rs1_addr,
    input  logic [`REG_IDX_W-1:0] rs2_addr,
    input  logic                  we,
    input  logic [`REG_IDX_W-1:0] wr_addr,
    input  logic [`XLEN-1:0]      wr_data,
    output logic [`XLEN-1:0]      rs1_data,
    output logic [`XLEN-1:0]      rs2_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin  // x0 never written
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* rename_issue.sv */
`timescale 1ns/1ns
`include "ooo_defines.svh"

module rename_issue (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  issue_valid,
    input  ooo_pkg::alu_op_e      issue_op,
    input  logic [`REG_IDX_W-1:0] issue_rs1,
    input  logic [`REG_IDX_W-1:0] issue_rs2,
    input  logic [`REG_IDX_W-1:0] issue_rd,
    input  logic [`ROB_IDX_W-1:0] alloc_idx,
    input  logic                  commit_valid,
    input  logic [`ROB_IDX_W-1:0] commit_idx,
    input  logic [`REG_IDX_W-1:0] commit_rd,
    input  logic                  flush,
    output logic                  src1_pending,
    output logic [`ROB_IDX_W-1:0] src1_tag,
    output logic                  src2_pending,
    output logic [`ROB_IDX_W-1:0] src2_tag
);
    import ooo_pkg::*;

    logic [`NUM_REGS-1:0]  busy;               // register has a producer in the window
    logic [`ROB_IDX_W-1:0] tag [`NUM_REGS];    // newest producer
    logic                  writes_rd;
    logic                  commit_frees;

    assign writes_rd = issue_valid && issue_op != OP_BEQ && issue_op != OP_BNE
                       && issue_rd != '0;

    // only the newest producer releases the alias
    assign commit_frees = commit_valid && busy[commit_rd] && tag[commit_rd] == commit_idx;

    // x0 is never marked busy, so it always reads as ready
    assign src1_pending = busy[issue_rs1];
    assign src1_tag     = tag[issue_rs1];
    assign src2_pending = busy[issue_rs2];
    assign src2_tag     = tag[issue_rs2];

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            busy <= '0;
        end else begin
            if (commit_frees) begin
                busy[commit_rd] <= 1'b0;
            end
            if (writes_rd) begin  // wins over a same-cycle commit to this register
                busy[issue_rd] <= 1'b1;
                tag[issue_rd]  <= alloc_idx;
            end
        end
    end

endmodule

/* rob_window.sv */
`timescale 1ns/1ns
`include "ooo_defines.svh"

module rob_window (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  issue_valid,
    input  ooo_pkg::alu_op_e      issue_op,
    input  logic [`REG_IDX_W-1:0] issue_rd,
    input  logic [`XLEN-1:0]      issue_imm,
    input  logic [`XLEN-1:0]      issue_pc,
    input  logic                  issue_pred_taken,
    input  logic                  src1_pending,
    input  logic [`ROB_IDX_W-1:0] src1_tag,
    input  logic                  src2_pending,
    input  logic [`ROB_IDX_W-1:0] src2_tag,
    input  logic [`XLEN-1:0]      rf_rs1_data,
    input  logic [`XLEN-1:0]      rf_rs2_data,
    input  logic                  exec_busy,
    input  logic                  done_valid,
    input  logic [`ROB_IDX_W-1:0] done_idx,
    input  logic [`XLEN-1:0]      done_value,
    input  logic [`XLEN-1:0]      done_next_pc,
    output logic                  issue_ready,
    output logic [`ROB_IDX_W-1:0] alloc_idx,
    output logic                  disp_valid,
    output logic [`ROB_IDX_W-1:0] disp_idx,
    output ooo_pkg::alu_op_e      disp_op,
    output logic [`XLEN-1:0]      disp_a,
    output logic [`XLEN-1:0]      disp_b,
    output logic [`XLEN-1:0]      disp_imm,
    output logic [`XLEN-1:0]      disp_pc,
    output logic                  commit_valid,
    output logic [`ROB_IDX_W-1:0] commit_idx,
    output logic [`REG_IDX_W-1:0] commit_rd,
    output logic                  rf_we,
    output logic [`REG_IDX_W-1:0] rf_rd,
    output logic [`XLEN-1:0]      rf_data,
    output logic                  flush,
    output logic [`XLEN-1:0]      redirect_pc
);
    import ooo_pkg::*;

    entry_state_e          state   [`ROB_DEPTH];
    alu_op_e               op_q    [`ROB_DEPTH];
    logic [`REG_IDX_W-1:0] rd_q    [`ROB_DEPTH];
    logic [`XLEN-1:0]      imm_q   [`ROB_DEPTH];
    logic [`XLEN-1:0]      pc_q    [`ROB_DEPTH];
    logic                  pred_q  [`ROB_DEPTH];
    logic [`XLEN-1:0]      a_val   [`ROB_DEPTH];
    logic [`ROB_IDX_W-1:0] a_tag   [`ROB_DEPTH];
    logic                  a_rdy   [`ROB_DEPTH];
    logic [`XLEN-1:0]      b_val   [`ROB_DEPTH];
    logic [`ROB_IDX_W-1:0] b_tag   [`ROB_DEPTH];
    logic                  b_rdy   [`ROB_DEPTH];
    logic [`XLEN-1:0]      result  [`ROB_DEPTH];
    logic [`XLEN-1:0]      next_pc [`ROB_DEPTH];  // actual next pc from the alu

    logic [`ROB_IDX_W-1:0] head;
    logic [`ROB_IDX_W-1:0] tail;
    logic [`ROB_IDX_W:0]   count;

    logic                  alloc;
    logic                  head_is_br;
    logic [`XLEN-1:0]      pred_pc;
    logic                  disp_any;
    logic [`ROB_IDX_W-1:0] sel;
    logic [`XLEN:0]        cap1;  // {ready, value} of each source at allocation
    logic [`XLEN:0]        cap2;

    // a pending source can still be caught from a finished or finishing producer
    function automatic logic [`XLEN:0] capture(input logic                  pending,
                                               input logic [`ROB_IDX_W-1:0] src_tag,
                                               input logic [`XLEN-1:0]      rf_val);
        logic [`XLEN:0] res;
        res = {1'b1, rf_val};
        if (pending) begin
            if (state[src_tag] == ST_DONE) begin
                res = {1'b1, result[src_tag]};
            end else if (done_valid && done_idx == src_tag) begin
                res = {1'b1, done_value};
            end else begin
                res = {1'b0, rf_val};
            end
        end
        return res;
    endfunction

    always_comb begin
        cap1 = capture(src1_pending, src1_tag, rf_rs1_data);
        cap2 = capture(src2_pending, src2_tag, rf_rs2_data);
    end

    assign issue_ready = count < (`ROB_IDX_W+1)'(`ROB_DEPTH);
    assign alloc       = issue_valid && issue_ready && !flush;
    assign alloc_idx   = tail;

    // lowest ready slot wins
    always_comb begin
        disp_any = 1'b0;
        sel      = '0;
        for (int i = `ROB_DEPTH - 1; i >= 0; i--) begin
            if (state[i] == ST_WAITING && a_rdy[i] && b_rdy[i]) begin
                disp_any = 1'b1;
                sel      = `ROB_IDX_W'(i);
            end
        end
    end

    assign disp_valid = disp_any && (!exec_busy || done_valid);
    assign disp_idx   = sel;
    assign disp_op    = op_q[sel];
    assign disp_a     = a_val[sel];
    assign disp_b     = b_val[sel];
    assign disp_imm   = imm_q[sel];
    assign disp_pc    = pc_q[sel];

    assign commit_valid = state[head] == ST_DONE;
    assign commit_idx   = head;
    assign commit_rd    = rd_q[head];
    assign head_is_br   = op_q[head] == OP_BEQ || op_q[head] == OP_BNE;
    assign pred_pc      = pred_q[head] ? pc_q[head] + imm_q[head] : pc_q[head] + `XLEN'(4);
    assign rf_we        = commit_valid && !head_is_br;
    assign rf_rd        = rd_q[head];
    assign rf_data      = result[head];
    assign flush        = commit_valid && head_is_br && next_pc[head] != pred_pc;
    assign redirect_pc  = next_pc[head];

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state[i] <= ST_EMPTY;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (commit_valid) begin
                state[head] <= ST_EMPTY;
                head        <= head + 1'b1;
            end
            if (alloc) begin
                state[tail]                <= ST_WAITING;
                op_q[tail]                 <= issue_op;
                rd_q[tail]                 <= issue_rd;
                imm_q[tail]                <= issue_imm;
                pc_q[tail]                 <= issue_pc;
                pred_q[tail]               <= issue_pred_taken;
                {a_rdy[tail], a_val[tail]} <= cap1;
                a_tag[tail]                <= src1_tag;
                {b_rdy[tail], b_val[tail]} <= cap2;
                b_tag[tail]                <= src2_tag;
                tail                       <= tail + 1'b1;
            end
            if (disp_valid) begin
                state[sel] <= ST_EXEC;
            end
            if (done_valid) begin
                state[done_idx]   <= ST_DONE;
                result[done_idx]  <= done_value;
                next_pc[done_idx] <= done_next_pc;
                for (int i = 0; i < `ROB_DEPTH; i++) begin  // wakeup
                    if (state[i] == ST_WAITING && !a_rdy[i] && a_tag[i] == done_idx) begin
                        a_rdy[i] <= 1'b1;
                        a_val[i] <= done_value;
                    end
                    if (state[i] == ST_WAITING && !b_rdy[i] && b_tag[i] == done_idx) begin
                        b_rdy[i] <= 1'b1;
                        b_val[i] <= done_value;
                    end
                end
            end
            count <= count + (`ROB_IDX_W+1)'(alloc) - (`ROB_IDX_W+1)'(commit_valid);
        end
    end

endmodule

/* alu_unit.sv */
`timescale 1ns/1ns
`include "ooo_defines.svh"

module alu_unit (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  flush,
    input  logic                  disp_valid,
    input  logic [`ROB_IDX_W-1:0] disp_idx,
    input  ooo_pkg::alu_op_e      disp_op,
    input  logic [`XLEN-1:0]      disp_a,
    input  logic [`XLEN-1:0]      disp_b,
    input  logic [`XLEN-1:0]      disp_imm,
    input  logic [`XLEN-1:0]      disp_pc,
    output logic                  exec_busy,
    output logic                  done_valid,
    output logic [`ROB_IDX_W-1:0] done_idx,
    output logic [`XLEN-1:0]      done_value,
    output logic [`XLEN-1:0]      done_next_pc
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

    logic             busy;
    logic [CNT_W-1:0] cnt;    // cycles left before done
    alu_op_e          op_q;
    logic [`XLEN-1:0] a_q;
    logic [`XLEN-1:0] b_q;
    logic [`XLEN-1:0] imm_q;
    logic [`XLEN-1:0] pc_q;
    logic             taken;

    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (disp_valid) begin  // may follow a done in the same cycle
            busy     <= 1'b1;
            cnt      <= (disp_op == OP_MUL) ? CNT_W'(`MUL_CYCLES - 1) : '0;
            done_idx <= disp_idx;
            op_q     <= disp_op;
            a_q      <= disp_a;
            b_q      <= disp_b;
            imm_q    <= disp_imm;
            pc_q     <= disp_pc;
        end else if (done_valid) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign exec_busy  = busy;
    assign done_valid = busy && cnt == '0;

    always_comb begin
        done_value = '0;
        taken      = 1'b0;
        case (op_q)
            OP_ADD:  done_value = a_q + b_q;
            OP_SUB:  done_value = a_q - b_q;
            OP_AND:  done_value = a_q & b_q;
            OP_OR:   done_value = a_q | b_q;
            OP_XOR:  done_value = a_q ^ b_q;
            OP_ADDI: done_value = a_q + imm_q;
            OP_MUL:  done_value = a_q * b_q;  // low half kept
            OP_BEQ:  taken = a_q == b_q;
            OP_BNE:  taken = a_q != b_q;
            default: done_value = '0;
        endcase
        done_next_pc = taken ? pc_q + imm_q : pc_q + `XLEN'(4);
    end

endmodule

/* ooo_core.sv */
`timescale 1ns/1ns
`include "ooo_defines.svh"

module ooo_core (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  issue_valid,
    input  ooo_pkg::alu_op_e      issue_op,
    input  logic [`REG_IDX_W-1:0] issue_rs1,
    input  logic [`REG_IDX_W-1:0] issue_rs2,
    input  logic [`REG_IDX_W-1:0] issue_rd,
    input  logic [`XLEN-1:0]      issue_imm,
    input  logic [`XLEN-1:0]      issue_pc,
    input  logic                  issue_pred_taken,
    output logic                  issue_ready,
    output logic                  rf_we,
    output logic [`REG_IDX_W-1:0] rf_rd,
    output logic [`XLEN-1:0]      rf_data,
    output logic                  flush,
    output logic [`XLEN-1:0]      redirect_pc
);
    import ooo_pkg::*;

    logic                  src1_pending;
    logic [`ROB_IDX_W-1:0] src1_tag;
    logic                  src2_pending;
    logic [`ROB_IDX_W-1:0] src2_tag;
    logic [`ROB_IDX_W-1:0] alloc_idx;
    logic [`XLEN-1:0]      rf_rs1_data;
    logic [`XLEN-1:0]      rf_rs2_data;
    logic                  issue_accept;  // issue taken by the window

    logic                  disp_valid;
    logic [`ROB_IDX_W-1:0] disp_idx;
    alu_op_e               disp_op;
    logic [`XLEN-1:0]      disp_a;
    logic [`XLEN-1:0]      disp_b;
    logic [`XLEN-1:0]      disp_imm;
    logic [`XLEN-1:0]      disp_pc;

    logic                  exec_busy;
    logic                  done_valid;
    logic [`ROB_IDX_W-1:0] done_idx;
    logic [`XLEN-1:0]      done_value;
    logic [`XLEN-1:0]      done_next_pc;

    logic                  commit_valid;
    logic [`ROB_IDX_W-1:0] commit_idx;
    logic [`REG_IDX_W-1:0] commit_rd;

    // the alias table only sees issues that get a window slot
    assign issue_accept = issue_valid && issue_ready;

    reg_file i_reg_file (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .rs1_addr (issue_rs1),
        .rs2_addr (issue_rs2),
        .we       (rf_we),
        .wr_addr  (rf_rd),
        .wr_data  (rf_data),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    rename_issue i_rename_issue (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .issue_valid  (issue_accept),
        .issue_op     (issue_op),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_rd     (issue_rd),
        .alloc_idx    (alloc_idx),
        .commit_valid (commit_valid),
        .commit_idx   (commit_idx),
        .commit_rd    (commit_rd),
        .flush        (flush),
        .src1_pending (src1_pending),
        .src1_tag     (src1_tag),
        .src2_pending (src2_pending),
        .src2_tag     (src2_tag)
    );

    rob_window i_rob_window (.*);

    alu_unit i_alu_unit (.*);

endmodule

/* tb_ooo_core.sv */
`timescale 1ns/1ns
`include "ooo_defines.svh"

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int N_INSTR         = 64;
    localparam int END_PC          = N_INSTR * 4;
    localparam int WATCHDOG_CYCLES = N_INSTR * 40;

    logic                  clk_in;
    logic                  rst_in;
    logic                  issue_valid;
    alu_op_e               issue_op;
    logic [`REG_IDX_W-1:0] issue_rs1;
    logic [`REG_IDX_W-1:0] issue_rs2;
    logic [`REG_IDX_W-1:0] issue_rd;
    logic [`XLEN-1:0]      issue_imm;
    logic [`XLEN-1:0]      issue_pc;
    logic                  issue_pred_taken;
    logic                  issue_ready;
    logic                  rf_we;
    logic [`REG_IDX_W-1:0] rf_rd;
    logic [`XLEN-1:0]      rf_data;
    logic                  flush;
    logic [`XLEN-1:0]      redirect_pc;

    alu_op_e               prog_op    [N_INSTR];
    logic [`REG_IDX_W-1:0] prog_rs1   [N_INSTR];
    logic [`REG_IDX_W-1:0] prog_rs2   [N_INSTR];
    logic [`REG_IDX_W-1:0] prog_rd    [N_INSTR];
    logic [`XLEN-1:0]      prog_imm   [N_INSTR];
    logic                  prog_pred  [N_INSTR];

    logic [31:0]           lfsr;
    logic [`XLEN-1:0]      fetch_pc;    // pc of the instruction on the issue port
    logic [`XLEN-1:0]      model_pc;    // next instruction expected to commit
    logic [`XLEN-1:0]      model_regs [`NUM_REGS];
    logic                  issued_any;
    logic                  saw_full;
    logic                  branch_issued;
    int                    outstanding;  // window occupancy while no branch is in flight
    int                    flush_count;
    int                    write_count;

    ooo_core i_ooo_core (.*);

    always #10 clk_in = ~clk_in;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic is_branch(input alu_op_e op);
        return op == OP_BEQ || op == OP_BNE;
    endfunction

    function automatic logic [`XLEN-1:0] alu_result(input int idx);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        a = model_regs[prog_rs1[idx]];
        b = model_regs[prog_rs2[idx]];
        case (prog_op[idx])
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + prog_imm[idx];
            OP_MUL:  return a * b;  // low 32 bits
            default: return '0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] actual_next_pc(input int idx);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic             taken;
        a     = model_regs[prog_rs1[idx]];
        b     = model_regs[prog_rs2[idx]];
        taken = (prog_op[idx] == OP_BEQ) ? (a == b) : (a != b);
        if (is_branch(prog_op[idx]) && taken) begin
            return `XLEN'(idx * 4) + prog_imm[idx];
        end
        return `XLEN'(idx * 4 + 4);
    endfunction

    function automatic logic [`XLEN-1:0] predicted_next_pc(input int idx);
        if (is_branch(prog_op[idx]) && prog_pred[idx]) begin
            return `XLEN'(idx * 4) + prog_imm[idx];
        end
        return `XLEN'(idx * 4 + 4);
    endfunction

    task automatic stop_on_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [`XLEN-1:0] got,
                                   input logic [`XLEN-1:0] exp);
        $display("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h", $time, sig, got, exp);
        stop_on_failure();
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_on_failure();
    endtask

    task automatic build_program();
        for (int i = 0; i < N_INSTR; i++) begin
            prog_rs1[i]  = '0;
            prog_rs2[i]  = '0;
            prog_rd[i]   = '0;
            prog_imm[i]  = '0;
            prog_pred[i] = 1'b0;
            if (i < 7) begin  // odd seeds in x1..x7 keep the product chain nonzero
                prog_op[i]  = OP_ADDI;
                prog_rd[i]  = `REG_IDX_W'(i + 1);
                prog_imm[i] = rand_bits(12) | 32'h1;
            end else if (i < 35) begin  // long dependent multiply chain fills the window
                prog_op[i]  = OP_MUL;
                prog_rs1[i] = `REG_IDX_W'(1);
                prog_rs2[i] = `REG_IDX_W'(2 + i % 6);
                prog_rd[i]  = `REG_IDX_W'(1);
            end else if (i == 35) begin  // always taken but predicted not taken
                prog_op[i]  = OP_BEQ;
                prog_imm[i] = `XLEN'(8);
            end else if (i == 36) begin  // only ever reached on the wrong path
                prog_op[i]  = OP_ADDI;
                prog_rs1[i] = `REG_IDX_W'(3);
                prog_rd[i]  = `REG_IDX_W'(3);
                prog_imm[i] = `XLEN'(32'h55);
            end else begin
                prog_op[i]  = alu_op_e'(4'(rand_bits(4) % 9));
                prog_rs1[i] = `REG_IDX_W'(rand_bits(3));
                prog_rs2[i] = `REG_IDX_W'(rand_bits(3));
                if (is_branch(prog_op[i])) begin
                    prog_imm[i]  = `XLEN'(4 * (1 + rand_bits(3) % (N_INSTR - i)));
                    prog_pred[i] = rand_bits(1) != 0;
                end else begin
                    prog_rd[i]  = `REG_IDX_W'(rand_bits(3));
                    prog_imm[i] = rand_bits(8);
                end
            end
        end
    endtask

    task automatic present_instr();
        int idx;
        idx = int'(fetch_pc >> 2);
        issue_valid      <= 1'b1;
        issue_op         <= prog_op[idx];
        issue_rs1        <= prog_rs1[idx];
        issue_rs2        <= prog_rs2[idx];
        issue_rd         <= prog_rd[idx];
        issue_imm        <= prog_imm[idx];
        issue_pc         <= fetch_pc;
        issue_pred_taken <= prog_pred[idx];
    endtask

    // correctly predicted branches commit without any visible pulse
    task automatic skip_predicted_branches();
        int idx;
        while (model_pc < END_PC) begin
            idx = int'(model_pc >> 2);
            if (!is_branch(prog_op[idx]) || actual_next_pc(idx) != predicted_next_pc(idx)) begin
                break;
            end
            model_pc = actual_next_pc(idx);
        end
    endtask

    task automatic check_reg_write();
        int               idx;
        logic [`XLEN-1:0] exp;
        assert (model_pc < END_PC)
            else report_error("register write after the last instruction committed");
        idx = int'(model_pc >> 2);
        assert (!is_branch(prog_op[idx]))
            else report_error("register write where a mispredicted branch should flush");
        exp = alu_result(idx);
        assert (rf_rd == prog_rd[idx])
            else report_mismatch("rf_rd", `XLEN'(rf_rd), `XLEN'(prog_rd[idx]));
        assert (rf_data == exp) else report_mismatch("rf_data", rf_data, exp);
        if (prog_rd[idx] != '0) begin
            model_regs[prog_rd[idx]] = exp;
        end
        model_pc    = model_pc + `XLEN'(4);
        write_count = write_count + 1;
    endtask

    task automatic check_redirect();
        int               idx;
        logic [`XLEN-1:0] exp;
        assert (model_pc < END_PC) else report_error("flush after the last instruction committed");
        idx = int'(model_pc >> 2);
        assert (is_branch(prog_op[idx]))
            else report_error("flush at the commit of a non-branch instruction");
        exp = actual_next_pc(idx);
        assert (redirect_pc == exp) else report_mismatch("redirect_pc", redirect_pc, exp);
        model_pc    = exp;
        flush_count = flush_count + 1;
    endtask

    // fetch follows the predicted path
    always @(posedge clk_in) begin
        if (rst_in) begin
            issue_valid <= 1'b0;
            fetch_pc = '0;
        end else begin
            if (flush) begin
                fetch_pc = redirect_pc;
            end else if (issue_valid && issue_ready) begin
                fetch_pc = predicted_next_pc(int'(fetch_pc >> 2));
            end
            if (fetch_pc < END_PC) begin
                present_instr();
            end else begin
                issue_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk_in) begin
        if (!rst_in) begin
            if (!issued_any) begin
                assert (!rf_we) else report_mismatch("rf_we", `XLEN'(rf_we), '0);
                assert (!flush) else report_mismatch("flush", `XLEN'(flush), '0);
            end
            if (!branch_issued) begin  // every commit is still visible on rf_we
                assert (issue_ready == (outstanding < `ROB_DEPTH))
                    else report_mismatch("issue_ready", `XLEN'(issue_ready),
                                         `XLEN'(outstanding < `ROB_DEPTH));
            end
            assert (!(rf_we && flush)) else report_error("register write during a flush");
            if (!issue_ready) begin
                saw_full = 1'b1;
            end
            skip_predicted_branches();
            if (rf_we) begin
                check_reg_write();
                outstanding = outstanding - 1;
            end
            if (flush) begin
                check_redirect();
            end
            if (issue_valid && issue_ready && !flush) begin
                issued_any  = 1'b1;
                outstanding = outstanding + 1;
                if (is_branch(issue_op)) begin
                    branch_issued = 1'b1;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        report_error("watchdog timeout before the program finished committing");
    end

    initial begin
        clk_in           = 1'b0;
        rst_in           = 1'b1;
        issue_valid      = 1'b0;
        issue_op         = OP_ADD;
        issue_rs1        = '0;
        issue_rs2        = '0;
        issue_rd         = '0;
        issue_imm        = '0;
        issue_pc         = '0;
        issue_pred_taken = 1'b0;
        lfsr             = 32'h9409_14b2;
        fetch_pc         = '0;
        model_pc         = '0;
        issued_any       = 1'b0;
        saw_full         = 1'b0;
        branch_issued    = 1'b0;
        outstanding      = 0;
        flush_count      = 0;
        write_count      = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        repeat (3) @(posedge clk_in);
        rst_in <= 1'b0;
        wait (model_pc >= END_PC);
        repeat (20) @(posedge clk_in);  // trailing branches drain
        assert (issue_ready) else report_mismatch("issue_ready", `XLEN'(issue_ready), `XLEN'(1));
        assert (saw_full) else report_error("issue_ready never went low with a full window");
        assert (flush_count > 0) else report_error("no mispredicted branch was flushed");
        $display("%0d register writes and %0d flushes checked", write_count, flush_count);
        $display("sim passed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
ooo_pkg.sv
reg_file.sv
rename_issue.sv
rob_window.sv
alu_unit.sv
ooo_core.sv
tb_ooo_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_ooo_core \
    && ./obj_dir/Vtb_ooo_core > sim.log 2>&1 \
    || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
